// ==== Makefile ====
# Verilator build and run of the bitonic merger testbench
# Any variable below can be set on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_bitonic_merger
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TB PASSED

SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.DEFAULT_GOAL := help

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it, log to $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables:"
	@echo "  VERILATOR BUILD_DIR LOG JOBS VFLAGS FLIST TOP"

$(SIM_BIN): $(FLIST) $(shell sed -n '/^[^+]/p' $(FLIST)) design/merge_cfg.svh
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-f $(FLIST) -Mdir $(BUILD_DIR) -o V$(TOP)

# The log decides the result, not the exit code of the simulator
test: $(SIM_BIN)
	rm -f $(LOG)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/merge_checker.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench monitor for the 16-key merger, predicts and compares
// Watches DUT ports and exposes its counts to the testbench top
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "merge_cfg.svh"

module merge_checker (
   input  wire logic              i_clk,
   input  wire logic              i_reset,
   input  wire logic              i_in_valid,
   input  merge_pkg::side_t       i_in_side,
   input  merge_pkg::half_t       i_in_lo,
   input  merge_pkg::half_t       i_in_hi,
   input  wire logic              i_out_valid,
   input  merge_pkg::side_t       i_out_side,
   input  merge_pkg::half_t       i_out_lo,
   input  merge_pkg::half_t       i_out_hi,
   output logic [31:0]            o_items,
   output logic [31:0]            o_value_errs,
   output logic [31:0]            o_proto_errs,
   output logic [31:0]            o_pending
);

   localparam int HK = `MERGE_HALF_KEYS;
   localparam int TW = `MERGE_TUPLE_W;
   localparam int FW = (HK * `MERGE_KEY_W > TW) ? HK * `MERGE_KEY_W : TW;

   // All sixteen keys, index 0 in the low bits
   typedef merge_pkg::key_t [2*HK-1:0] all_t;

   // One predicted item plus the cycle it was accepted in
   typedef struct packed {
      logic [31:0]      stamp;
      merge_pkg::side_t side;
      merge_pkg::half_t lo;
      merge_pkg::half_t hi;
   } exp_t;

   exp_t exp_q[$];
   int   cycle      = 0;
   int   items      = 0;
   int   value_errs = 0;
   int   proto_errs = 0;
   logic reset_d    = 1'b0;

   // Selection sort, ascending unsigned
   function automatic all_t sort_all(input merge_pkg::half_t lo, input merge_pkg::half_t hi);
      all_t            a;
      merge_pkg::key_t t;
      int              m;
      a = {hi, lo};
      for (int i = 0; i < 2*HK - 1; i++) begin
         m = i;
         for (int j = i + 1; j < 2*HK; j++) begin
            if (a[j] < a[m]) begin
               m = j;
            end
         end
         t    = a[i];
         a[i] = a[m];
         a[m] = t;
      end
      return a;
   endfunction

   task automatic compare_field(input string name, input logic [FW-1:0] exp,
                                input logic [FW-1:0] got);
      if (got !== exp) begin
         value_errs++;
         $display("ERROR %s expected %h actual %h", name, exp, got);
      end
   endtask

   always @(posedge i_clk) begin : watch
      exp_t exp_item;
      all_t sorted;
      cycle++;
      // Output must stay low while reset is applied and one cycle after
      if (reset_d && i_out_valid !== 1'b0) begin
         proto_errs++;
         $display("o_valid was not low during or right after reset, cycle %0d", cycle);
      end
      reset_d = i_reset;
      if (!i_reset && i_out_valid === 1'bx) begin
         proto_errs++;
         $display("o_valid is unknown at cycle %0d", cycle);
      end
      if (!i_reset && i_out_valid === 1'b1) begin
         if (exp_q.size() == 0) begin
            proto_errs++;
            $display("output at cycle %0d has no matching input", cycle);
         end else begin
            exp_item = exp_q.pop_front();
            items++;
            if (cycle - exp_item.stamp != `MERGE_STAGES) begin
               proto_errs++;
               $display("item accepted at cycle %0d left at cycle %0d, latency must be %0d",
                        exp_item.stamp, cycle, `MERGE_STAGES);
            end
            compare_field("o_lo", exp_item.lo, i_out_lo);
            compare_field("o_hi", exp_item.hi, i_out_hi);
            compare_field("o_side.top_tuple", exp_item.side.top_tuple, i_out_side.top_tuple);
            if (i_out_side.switch_out !== exp_item.side.switch_out) begin
               value_errs++;
               $display("ERROR o_side.switch_out expected %h actual %h",
                        exp_item.side.switch_out, i_out_side.switch_out);
            end
         end
      end
      // Prediction for the item entering this cycle
      if (!i_reset && i_in_valid === 1'b1) begin
         sorted         = sort_all(i_in_lo, i_in_hi);
         exp_item.stamp = cycle;
         exp_item.side  = i_in_side;
         exp_item.lo    = sorted[HK-1:0];
         exp_item.hi    = sorted[2*HK-1:HK];
         exp_q.push_back(exp_item);
      end
   end

   assign o_items      = items;
   assign o_value_errs = value_errs;
   assign o_proto_errs = proto_errs;
   assign o_pending    = exp_q.size();

endmodule

`default_nettype wire

// ==== bench/tb_bitonic_merger.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the 16-key bitonic merger
// Drives random and corner items, the checker module does the compare
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "merge_cfg.svh"

module tb_bitonic_merger;

   localparam int          HK            = `MERGE_HALF_KEYS;
   localparam int          TW            = `MERGE_TUPLE_W;
   localparam int          CLK_PERIOD_NS = 4;
   localparam int          RESET_CYC     = 8;
   localparam int          N_RAND        = 48;
   localparam int          N_CORNER      = 6;
   localparam int          N_GAP         = 48;
   localparam int          DRAIN_CYC     = `MERGE_STAGES + 4;
   localparam int          MARGIN_CYC    = 50;
   localparam int          TOTAL_CYC     = RESET_CYC + N_RAND + N_CORNER + N_GAP + DRAIN_CYC;
   localparam int          WATCHDOG_NS   = (TOTAL_CYC + `MERGE_STAGES + MARGIN_CYC) * CLK_PERIOD_NS;
   localparam logic [31:0] SEED          = 32'h3310_4a07;

   logic             i_clk = 1'b0;
   logic             i_reset;
   logic             i_valid;
   merge_pkg::side_t i_side;
   merge_pkg::half_t i_lo;
   merge_pkg::half_t i_hi;
   logic             o_valid;
   merge_pkg::side_t o_side;
   merge_pkg::half_t o_lo;
   merge_pkg::half_t o_hi;

   logic [31:0]      chk_items;
   logic [31:0]      chk_value_errs;
   logic [31:0]      chk_proto_errs;
   logic [31:0]      chk_pending;
   logic [31:0]      lcg_state;
   int               sent = 0;

   always #(CLK_PERIOD_NS / 2) i_clk = ~i_clk;

   bitonic_merger_16 uut (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_valid (i_valid),
      .i_side  (i_side),
      .i_lo    (i_lo),
      .i_hi    (i_hi),
      .o_valid (o_valid),
      .o_side  (o_side),
      .o_lo    (o_lo),
      .o_hi    (o_hi)
   );

   merge_checker u_chk (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_in_valid   (i_valid),
      .i_in_side    (i_side),
      .i_in_lo      (i_lo),
      .i_in_hi      (i_hi),
      .i_out_valid  (o_valid),
      .i_out_side   (o_side),
      .i_out_lo     (o_lo),
      .i_out_hi     (o_hi),
      .o_items      (chk_items),
      .o_value_errs (chk_value_errs),
      .o_proto_errs (chk_proto_errs),
      .o_pending    (chk_pending)
   );

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic next_word(output logic [31:0] w);
      lcg_state = lcg_step(lcg_state);
      w         = lcg_state;
   endtask

   // Inputs must arrive ascending
   function automatic merge_pkg::half_t sort_half(input merge_pkg::half_t h);
      merge_pkg::half_t r;
      merge_pkg::key_t  t;
      r = h;
      for (int p = 0; p < HK - 1; p++) begin
         for (int i = 0; i < HK - 1 - p; i++) begin
            if (r[i] > r[i + 1]) begin
               t        = r[i];
               r[i]     = r[i + 1];
               r[i + 1] = t;
            end
         end
      end
      return r;
   endfunction

   task automatic random_half(output merge_pkg::half_t h, input logic narrow);
      logic [31:0] w;
      for (int i = 0; i < HK; i++) begin
         next_word(w);
         // Narrow range forces many equal keys
         h[i] = narrow ? {28'h0, w[31:28]} : w;
      end
      h = sort_half(h);
   endtask

   task automatic random_side(output merge_pkg::side_t s);
      logic [31:0] w;
      for (int i = 0; i < TW / 32; i++) begin
         next_word(w);
         s.top_tuple[i*32 +: 32] = w;
      end
      next_word(w);
      s.switch_out = w[31];
   endtask

   task automatic drive_item(input logic valid, input merge_pkg::half_t lo,
                             input merge_pkg::half_t hi);
      merge_pkg::side_t side;
      random_side(side);
      @(posedge i_clk);
      i_valid <= valid;
      i_side  <= side;
      i_lo    <= lo;
      i_hi    <= hi;
      if (valid) begin
         sent++;
      end
   endtask

   task automatic send_corners();
      merge_pkg::half_t lo;
      merge_pkg::half_t hi;
      drive_item(1'b1, '0, '0);
      drive_item(1'b1, '1, '1);
      // Runs of duplicates at both ends of the key range
      for (int i = 0; i < HK; i++) begin
         lo[i] = (i < 3) ? 32'h0 : (i < 5) ? 32'h5 : 32'hFFFF_FFFF;
         hi[i] = (i < 2) ? 32'h0 : (i < 6) ? 32'h5 : 32'hFFFF_FFFF;
      end
      drive_item(1'b1, lo, hi);
      for (int i = 0; i < HK; i++) begin
         lo[i] = 2 * i;
         hi[i] = 2 * i + 1;
      end
      drive_item(1'b1, lo, hi);
      // Already split, then split the other way round
      for (int i = 0; i < HK; i++) begin
         lo[i] = i;
         hi[i] = HK + i;
      end
      drive_item(1'b1, lo, hi);
      for (int i = 0; i < HK; i++) begin
         lo[i] = 100 + i;
         hi[i] = i;
      end
      drive_item(1'b1, lo, hi);
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog timeout after %0d ns, stimulus or drain never finished", WATCHDOG_NS);
      $display("TB FAILED");
      $finish;
   end

   initial begin
      merge_pkg::half_t lo;
      merge_pkg::half_t hi;
      logic [31:0]      w;
      int               total;
      i_reset   = 1'b1;
      i_valid   = 1'b0;
      i_side    = '0;
      i_lo      = '0;
      i_hi      = '0;
      lcg_state = SEED;
      repeat (RESET_CYC) @(posedge i_clk);
      i_reset <= 1'b0;
      // Back to back random items
      for (int n = 0; n < N_RAND; n++) begin
         random_half(lo, 1'b0);
         random_half(hi, 1'b0);
         drive_item(1'b1, lo, hi);
      end
      send_corners();
      // Random gaps, narrow keys
      for (int n = 0; n < N_GAP; n++) begin
         next_word(w);
         random_half(lo, 1'b1);
         random_half(hi, 1'b1);
         drive_item(w[31], lo, hi);
      end
      repeat (DRAIN_CYC) begin
         @(posedge i_clk);
         i_valid <= 1'b0;
      end
      @(posedge i_clk);
      total = chk_value_errs + chk_proto_errs + chk_pending;
      $display("items sent %0d, checked %0d, value errors %0d, protocol errors %0d, pending %0d",
               sent, chk_items, chk_value_errs, chk_proto_errs, chk_pending);
      if (chk_pending != 0) begin
         $display("%0d expected items never reached the output", chk_pending);
      end
      if (total == 0 && chk_items == sent) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== design/bitonic_merger_16.sv ====
//////////////////////////////////////////////////////////////////////
// Pipelined merger of two sorted 8-key halves into 16 sorted keys
// Accepts one item per valid cycle and returns it four cycles later
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module bitonic_merger_16 (
   input  wire logic            i_clk,
   input  wire logic            i_reset,
   input  wire logic            i_valid,
   input  merge_pkg::side_t     i_side,
   input  merge_pkg::half_t     i_lo,
   input  merge_pkg::half_t     i_hi,
   output logic                 o_valid,
   output merge_pkg::side_t     o_side,
   output merge_pkg::half_t     o_lo,
   output merge_pkg::half_t     o_hi
);

   merge_pkg::beat_t in_beat;
   merge_pkg::beat_t flip_beat;
   merge_pkg::beat_t d4_beat;
   merge_pkg::beat_t d2_beat;
   merge_pkg::beat_t out_beat;

   assign in_beat = '{valid: i_valid, side: i_side, lo: i_lo, hi: i_hi};

   // Split into two bitonic halves
   merge_flip_stage u_flip (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_beat  (in_beat),
      .o_beat  (flip_beat)
   );

   // Then sort each half with three cleaner levels
   merge_half_cleaner #(
      .DIST (4)
   ) u_clean_d4 (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_beat  (flip_beat),
      .o_beat  (d4_beat)
   );

   merge_half_cleaner #(
      .DIST (2)
   ) u_clean_d2 (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_beat  (d4_beat),
      .o_beat  (d2_beat)
   );

   merge_half_cleaner #(
      .DIST (1)
   ) u_clean_d1 (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_beat  (d2_beat),
      .o_beat  (out_beat)
   );

   assign o_valid = out_beat.valid;
   assign o_side  = out_beat.side;
   assign o_lo    = out_beat.lo;
   assign o_hi    = out_beat.hi;

   // Whole valid chain is cleared by one reset cycle
   a_reset_clears: assert property (
      @(posedge i_clk)
      i_reset |=> !o_valid
   ) else $error("o_valid high right after reset");

endmodule

`default_nettype wire

// ==== design/merge_cfg.svh ====
//////////////////////////////////////////////////////////////////////
// Size settings for the 16-key bitonic merger pipeline
// Included by the package, the stages and the testbench
//////////////////////////////////////////////////////////////////////

`ifndef MERGE_CFG_SVH
`define MERGE_CFG_SVH

// Width of one unsigned key
`define MERGE_KEY_W 32

// Keys in each of the two input halves
// Stage wiring assumes a power of two
`define MERGE_HALF_KEYS 8

// Sideband tuple that rides along with every item
`define MERGE_TUPLE_W 256

// Cycles from input sample to output
// One flip stage plus one half cleaner per level inside a half
`define MERGE_STAGES 4

`endif

// ==== design/merge_flip_stage.sv ====
//////////////////////////////////////////////////////////////////////
// First merge step, compare-exchange of mirrored keys across halves
// Output is a bitonic split: every low key is at most every high key
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "merge_cfg.svh"

module merge_flip_stage (
   input  wire logic            i_clk,
   input  wire logic            i_reset,
   input  merge_pkg::beat_t     i_beat,
   output merge_pkg::beat_t     o_beat
);

   localparam int HK = `MERGE_HALF_KEYS;

   merge_pkg::half_t lo_nxt;
   merge_pkg::half_t hi_nxt;

   logic             valid_q;
   merge_pkg::side_t side_q;
   merge_pkg::half_t lo_q;
   merge_pkg::half_t hi_q;

   // lo[i] meets hi[HK-1-i], both halves ascending on input
   always_comb begin
      for (int i = 0; i < HK; i++) begin
         if (i_beat.lo[i] > i_beat.hi[HK-1-i]) begin
            lo_nxt[i]      = i_beat.hi[HK-1-i];
            hi_nxt[HK-1-i] = i_beat.lo[i];
         end else begin
            lo_nxt[i]      = i_beat.lo[i];
            hi_nxt[HK-1-i] = i_beat.hi[HK-1-i];
         end
      end
   end

   // Valid follows the input every cycle
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= i_beat.valid;
      end
   end

   // Data and sideband hold while no item arrives
   always_ff @(posedge i_clk) begin
      if (i_beat.valid) begin
         side_q <= i_beat.side;
         lo_q   <= lo_nxt;
         hi_q   <= hi_nxt;
      end
   end

   assign o_beat = '{valid: valid_q, side: side_q, lo: lo_q, hi: hi_q};

   // Each pair written one cycle later is in order
   for (genvar g = 0; g < HK; g++) begin : g_pair_chk
      a_pair_order: assert property (
         @(posedge i_clk) disable iff (i_reset)
         i_beat.valid |=> (o_beat.lo[g] <= o_beat.hi[HK-1-g])
      ) else $error("flip stage pair %0d out of order", g);
   end

endmodule

`default_nettype wire

// ==== design/merge_half_cleaner.sv ====
//////////////////////////////////////////////////////////////////////
// One bitonic half-cleaner step, applied to both halves in parallel
// DIST selects the compare distance, chained as 4, 2 then 1
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "merge_cfg.svh"

module merge_half_cleaner #(
   parameter int DIST = 4
) (
   input  wire logic            i_clk,
   input  wire logic            i_reset,
   input  merge_pkg::beat_t     i_beat,
   output merge_pkg::beat_t     o_beat
);

   localparam int HK = `MERGE_HALF_KEYS;

   merge_pkg::half_t lo_nxt;
   merge_pkg::half_t hi_nxt;

   logic             valid_q;
   merge_pkg::side_t side_q;
   merge_pkg::half_t lo_q;
   merge_pkg::half_t hi_q;

   // Compare-exchange every index with the DIST bit clear
   // against its partner DIST places above, smaller key goes low
   function automatic merge_pkg::half_t clean_half(input merge_pkg::half_t h);
      merge_pkg::half_t r;
      int               j;
      r = h;
      for (int p = 0; p < HK / 2; p++) begin
         // p-th pair, skipping the upper member of each group
         j = ((p / DIST) * 2 * DIST) + (p % DIST);
         if (h[j] > h[j + DIST]) begin
            r[j]        = h[j + DIST];
            r[j + DIST] = h[j];
         end
      end
      return r;
   endfunction

   // Both halves are cleaned independently
   always_comb begin
      lo_nxt = clean_half(i_beat.lo);
      hi_nxt = clean_half(i_beat.hi);
   end

   // Valid pipeline, cleared by reset
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= i_beat.valid;
      end
   end

   // Payload registers load only on a valid item
   always_ff @(posedge i_clk) begin
      if (i_beat.valid) begin
         side_q <= i_beat.side;
         lo_q   <= lo_nxt;
         hi_q   <= hi_nxt;
      end
   end

   assign o_beat = '{valid: valid_q, side: side_q, lo: lo_q, hi: hi_q};

   // Pair indexing above only works for a power of two inside a half
   a_dist_legal: assert property (
      @(posedge i_clk)
      (DIST > 0) && (DIST < HK) && ((DIST & (DIST - 1)) == 0)
   ) else $error("half cleaner DIST %0d is not a power of two below %0d", DIST, HK);

endmodule

`default_nettype wire

// ==== design/merge_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Types shared by the merger stages and the top level
// Sizes come from the config header
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "merge_cfg.svh"

package merge_pkg;

   // One unsigned key
   typedef logic [`MERGE_KEY_W-1:0] key_t;

   // Eight keys, index 0 in the low bits
   typedef key_t [`MERGE_HALF_KEYS-1:0] half_t;

   // Values carried untouched next to the keys
   typedef struct packed {
      logic                      switch_out;
      logic [`MERGE_TUPLE_W-1:0] top_tuple;
   } side_t;

   // Bundle passed from one stage to the next
   typedef struct packed {
      logic  valid;
      side_t side;
      half_t lo;
      half_t hi;
   } beat_t;

endpackage

`default_nettype wire

// ==== flist.f ====
+incdir+design
design/merge_pkg.sv
design/merge_flip_stage.sv
design/merge_half_cleaner.sv
design/bitonic_merger_16.sv
bench/merge_checker.sv
bench/tb_bitonic_merger.sv
